//--- design/cpuFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module cpuFrontEnd #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  wire logic            clk,
  input  wire logic            rstN,
  output logic [31:0]          instrAddr,
  input  wire logic [31:0]     instrData,
  input  wire logic            stall,
  input  wire cpuPkg::wbPort_t wb,
  output cpuPkg::idExEntry_t   idEx
);

  logic [31:0]        fetchPcPlusFour;
  cpuPkg::redirect_t  redirect;
  cpuPkg::ifIdEntry_t ifIdIn;
  cpuPkg::ifIdEntry_t ifIdOut;
  cpuPkg::idExEntry_t idExNext;

  ////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////
  instrFetch #(
    .resetPc (resetPc)
  ) u_instrFetch (
    .clk        (clk),
    .rstN       (rstN),
    .stall      (stall),
    .redirect   (redirect),
    .pc         (instrAddr),
    .pcPlusFour (fetchPcPlusFour)
  );

  // Memory word returns in the same cycle
  assign ifIdIn = '{valid: 1'b1, instruction: instrData, pcPlusFour: fetchPcPlusFour};

  // IF/ID holds under stall, flushed by a redirect
  pipeReg #(
    .payload_t     (cpuPkg::ifIdEntry_t),
    .bubbleOnStall (1'b0)
  ) u_ifIdReg (
    .clk   (clk),
    .rstN  (rstN),
    .stall (stall),
    .flush (redirect.taken),
    .din   (ifIdIn),
    .dout  (ifIdOut)
  );

  ////////////////////////////////////////////////////////////
  // Decode and ID/EX
  ////////////////////////////////////////////////////////////
  instrDecode u_instrDecode (
    .clk      (clk),
    .rstN     (rstN),
    .ifId     (ifIdOut),
    .wb       (wb),
    .redirect (redirect),
    .idExNext (idExNext)
  );

  // Bubble inserted while IF/ID holds
  pipeReg #(
    .payload_t     (cpuPkg::idExEntry_t),
    .bubbleOnStall (1'b1)
  ) u_idExReg (
    .clk   (clk),
    .rstN  (rstN),
    .stall (stall),
    .flush (1'b0),
    .din   (idExNext),
    .dout  (idEx)
  );

endmodule

`default_nettype wire

//--- design/cpuPkg.sv
`default_nettype none

package cpuPkg;

  ////////////////////////////////////////////////////////////
  // Opcodes, instruction bits 31:26
  ////////////////////////////////////////////////////////////
  localparam logic [5:0] opRType = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opJal   = 6'h03;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opBne   = 6'h05;
  localparam logic [5:0] opAddi  = 6'h08;
  localparam logic [5:0] opLb    = 6'h20;
  localparam logic [5:0] opLh    = 6'h21;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSb    = 6'h28;
  localparam logic [5:0] opSh    = 6'h29;
  localparam logic [5:0] opSw    = 6'h2b;

  // R-type function codes, bits 5:0
  localparam logic [5:0] fnJr  = 6'h08;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // ALU operand B source
  localparam logic [1:0] aluSrc1Reg  = 2'd0;
  localparam logic [1:0] aluSrc1Imm  = 2'd1;
  localparam logic [1:0] aluSrc1Zero = 2'd2;

  // Destination register select
  localparam logic [1:0] regDstRt   = 2'd0;
  localparam logic [1:0] regDstRd   = 2'd1;
  localparam logic [1:0] regDstLink = 2'd2;

  // Memory access width
  typedef enum logic [1:0] {
    widthByte = 2'd0,
    widthHalf = 2'd1,
    widthWord = 2'd2
  } memWidth_t;

  ////////////////////////////////////////////////////////////
  // Stage bundles
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic      regSrc0;   // rs read as 31
    logic      regSrc1;   // rt read as 0
    logic      aluSrc0;   // 1 selects PC+4 as operand A
    logic [1:0] aluSrc1;
    logic [1:0] regDst;
    logic      rdEnable;
    logic      wrEnable;
    memWidth_t rdWidth;
    memWidth_t wrWidth;
    logic      memToReg;
    logic      regWrite;
  } ctrlBundle_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] instruction;
    logic [31:0] pcPlusFour;
  } ifIdEntry_t;

  typedef struct packed {
    logic        valid;
    ctrlBundle_t ctrl;
    logic [31:0] regData1;
    logic [31:0] regData2;
    logic [31:0] imm32;
    logic [4:0]  destReg;
    logic [31:0] pcPlusFour;
  } idExEntry_t;

  // Write-back strobe from the back end
  typedef struct packed {
    logic        regWrite;
    logic [4:0]  destReg;
    logic [31:0] data;
  } wbPort_t;

  typedef struct packed {
    logic        taken;
    logic [31:0] target;
  } redirect_t;

endpackage

`default_nettype wire

//--- design/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire cpuPkg::ifIdEntry_t ifId,
  input  wire cpuPkg::wbPort_t    wb,
  output cpuPkg::redirect_t       redirect,
  output cpuPkg::idExEntry_t      idExNext
);

  logic [31:0] instr;
  logic [4:0]  rsField;
  logic [4:0]  rtField;
  logic [4:0]  rdField;

  cpuPkg::ctrlBundle_t ctrl;
  logic isBranch;
  logic isBne;
  logic isJump;
  logic isJumpReg;

  logic [4:0]  rsSel;
  logic [4:0]  rtSel;
  logic [31:0] regData1;
  logic [31:0] regData2;
  logic [31:0] imm32;
  logic [4:0]  destReg;

  logic        regEqual;
  logic        branchTaken;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;

  assign instr   = ifId.instruction;
  assign rsField = instr[25:21];
  assign rtField = instr[20:16];
  assign rdField = instr[15:11];

  ////////////////////////////////////////////////////////////
  // Control and register reads
  ////////////////////////////////////////////////////////////
  mainControl u_mainControl (
    .opcode    (instr[31:26]),
    .funct     (instr[5:0]),
    .ctrl      (ctrl),
    .isBranch  (isBranch),
    .isBne     (isBne),
    .isJump    (isJump),
    .isJumpReg (isJumpReg)
  );

  // Source overrides from the control word
  assign rsSel = ctrl.regSrc0 ? 5'd31 : rsField;
  assign rtSel = ctrl.regSrc1 ? 5'd0 : rtField;

  regFile u_regFile (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddr1 (rsSel),
    .rdAddr2 (rtSel),
    .wb      (wb),
    .rdData1 (regData1),
    .rdData2 (regData2)
  );

  assign imm32 = {{16{instr[15]}}, instr[15:0]};

  always_comb begin
    case (ctrl.regDst)
      cpuPkg::regDstRd:   destReg = rdField;
      cpuPkg::regDstLink: destReg = 5'd31;
      default:            destReg = rtField;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Branch and jump resolution
  ////////////////////////////////////////////////////////////
  assign regEqual     = (regData1 == regData2);
  assign branchTaken  = isBranch && (isBne ? !regEqual : regEqual);
  assign branchTarget = ifId.pcPlusFour + {imm32[29:0], 2'b00};
  // Region jump keeps the top nibble of PC+4
  assign jumpTarget   = {ifId.pcPlusFour[31:28], instr[25:0], 2'b00};

  // Bubbles never redirect
  assign redirect.taken = ifId.valid && (branchTaken || isJump || isJumpReg);

  always_comb begin
    if (isJumpReg) begin
      redirect.target = regData1;
    end else if (isJump) begin
      redirect.target = jumpTarget;
    end else begin
      redirect.target = branchTarget;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next ID/EX entry
  ////////////////////////////////////////////////////////////
  always_comb begin
    idExNext.valid      = ifId.valid;
    // Bubble carries no enables downstream
    idExNext.ctrl       = ifId.valid ? ctrl : '0;
    idExNext.regData1   = regData1;
    idExNext.regData2   = regData2;
    idExNext.imm32      = imm32;
    idExNext.destReg    = destReg;
    idExNext.pcPlusFour = ifId.pcPlusFour;
  end

endmodule

`default_nettype wire

//--- design/instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetch #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               stall,
  input  wire cpuPkg::redirect_t  redirect,
  output logic [31:0]             pc,
  output logic [31:0]             pcPlusFour
);

  ////////////////////////////////////////////////////////////
  // Sequential successor of the current fetch address
  ////////////////////////////////////////////////////////////
  assign pcPlusFour = pc + 32'd4;

  // Priority: reset, redirect, stall, increment
  // A redirect overrides a stall so the branch target is never missed
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= resetPc;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else if (!stall) begin
      pc <= pcPlusFour;
    end
    // Otherwise hold for the stalled cycle
  end

endmodule

`default_nettype wire

//--- design/mainControl.sv
`timescale 1ns/1ps
`default_nettype none

module mainControl (
  input  wire logic [5:0]    opcode,
  input  wire logic [5:0]    funct,
  output cpuPkg::ctrlBundle_t ctrl,
  output logic               isBranch,
  output logic               isBne,
  output logic               isJump,
  output logic               isJumpReg
);

  ////////////////////////////////////////////////////////////
  // Decode table
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Safe default, no register or memory write
    ctrl      = '0;
    isBranch  = 1'b0;
    isBne     = 1'b0;
    isJump    = 1'b0;
    isJumpReg = 1'b0;

    case (opcode)
      cpuPkg::opRType: begin
        case (funct)
          cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd,
          cpuPkg::fnOr, cpuPkg::fnSlt: begin
            ctrl.aluSrc1  = cpuPkg::aluSrc1Reg;
            ctrl.regDst   = cpuPkg::regDstRd;
            ctrl.regWrite = 1'b1;
          end
          cpuPkg::fnJr: begin
            // Only rs is needed
            ctrl.regSrc1 = 1'b1;
            isJumpReg    = 1'b1;
          end
          default: ;
        endcase
      end

      cpuPkg::opAddi: begin
        ctrl.regSrc1  = 1'b1;
        ctrl.aluSrc1  = cpuPkg::aluSrc1Imm;
        ctrl.regDst   = cpuPkg::regDstRt;
        ctrl.regWrite = 1'b1;
      end

      // Loads, address is rs + imm, rt is the destination
      cpuPkg::opLb, cpuPkg::opLh, cpuPkg::opLw: begin
        ctrl.regSrc1  = 1'b1;
        ctrl.aluSrc1  = cpuPkg::aluSrc1Imm;
        ctrl.regDst   = cpuPkg::regDstRt;
        ctrl.rdEnable = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        case (opcode)
          cpuPkg::opLb: ctrl.rdWidth = cpuPkg::widthByte;
          cpuPkg::opLh: ctrl.rdWidth = cpuPkg::widthHalf;
          default:      ctrl.rdWidth = cpuPkg::widthWord;
        endcase
      end

      // Stores, rt carries the store data
      cpuPkg::opSb, cpuPkg::opSh, cpuPkg::opSw: begin
        ctrl.aluSrc1  = cpuPkg::aluSrc1Imm;
        ctrl.wrEnable = 1'b1;
        case (opcode)
          cpuPkg::opSb: ctrl.wrWidth = cpuPkg::widthByte;
          cpuPkg::opSh: ctrl.wrWidth = cpuPkg::widthHalf;
          default:      ctrl.wrWidth = cpuPkg::widthWord;
        endcase
      end

      cpuPkg::opBeq, cpuPkg::opBne: begin
        ctrl.aluSrc1 = cpuPkg::aluSrc1Reg;
        isBranch     = 1'b1;
        isBne        = (opcode == cpuPkg::opBne);
      end

      cpuPkg::opJ: begin
        ctrl.regSrc1 = 1'b1;
        isJump       = 1'b1;
      end

      // Link value is PC+4 + 0 written to r31
      cpuPkg::opJal: begin
        ctrl.regSrc0  = 1'b1;
        ctrl.regSrc1  = 1'b1;
        ctrl.aluSrc0  = 1'b1;
        ctrl.aluSrc1  = cpuPkg::aluSrc1Zero;
        ctrl.regDst   = cpuPkg::regDstLink;
        ctrl.regWrite = 1'b1;
        isJump        = 1'b1;
      end

      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
  parameter type payload_t     = logic,
  parameter bit  bubbleOnStall = 1'b0
) (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire logic stall,
  input  wire logic flush,
  input  wire payload_t din,
  output payload_t  dout
);

  ////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////
  // All-zero payload is the bubble, valid bit low
  // Flush beats stall so a redirect always kills the entry
  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      dout <= '0;
    end else if (!stall) begin
      dout <= din;
    end else if (bubbleOnStall) begin
      // Downstream of the stall point, the held entry replays later
      dout <= '0;
    end
    // Upstream of the stall point, hold
  end

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire logic            clk,
  input  wire logic            rstN,
  input  wire logic [4:0]      rdAddr1,
  input  wire logic [4:0]      rdAddr2,
  input  wire cpuPkg::wbPort_t wb,
  output logic [31:0]          rdData1,
  output logic [31:0]          rdData2
);

  // r1..r31 only, r0 has no storage
  logic [31:0] regs [1:31];

  logic wrValid;

  assign wrValid = wb.regWrite && (wb.destReg != 5'd0);

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrValid) begin
      regs[wb.destReg] <= wb.data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports with write-through bypass
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (rdAddr1 == 5'd0) begin
      rdData1 = '0;
    end else if (wrValid && (wb.destReg == rdAddr1)) begin
      rdData1 = wb.data;
    end else begin
      rdData1 = regs[rdAddr1];
    end

    if (rdAddr2 == 5'd0) begin
      rdData2 = '0;
    end else if (wrValid && (wb.destReg == rdAddr2)) begin
      rdData2 = wb.data;
    end else begin
      rdData2 = regs[rdAddr2];
    end
  end

endmodule

`default_nettype wire

//--- dv/cpuFrontEnd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpuFrontEnd_checker #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input wire logic               clk,
  input wire logic               rstN,
  input wire logic [31:0]        instrAddr,
  input wire logic [31:0]        instrData,
  input wire logic               stall,
  input wire cpuPkg::wbPort_t    wb,
  input wire cpuPkg::idExEntry_t idEx
);

  // Count of failed assertions
  int failCount = 0;

  // Shadow register file and shadow IF/ID entry
  logic [31:0]        shadowRegs [32];
  logic               ifValid;
  logic [31:0]        ifInstr;
  logic [31:0]        ifPcPlusFour;
  logic               takenQ;
  cpuPkg::idExEntry_t expIdEx;

  // Reference decode of the shadow IF/ID entry
  cpuPkg::ctrlBundle_t refCtrl;
  logic [4:0]          srcA;
  logic [4:0]          srcB;
  logic [31:0]         dataA;
  logic [31:0]         dataB;
  logic [31:0]         refImm;
  logic [31:0]         refTarget;
  logic                refTaken;
  cpuPkg::idExEntry_t  refEntry;

  ////////////////////////////////////////////////////////////
  // Decode table
  ////////////////////////////////////////////////////////////
  function automatic cpuPkg::ctrlBundle_t decodeCtrl(input logic [31:0] ins);
    cpuPkg::ctrlBundle_t c;
    c = '0;
    case (ins[31:26])
      cpuPkg::opRType: begin
        if (ins[5:0] == cpuPkg::fnJr) begin
          c.regSrc1 = 1'b1;
        end else if (ins[5:0] inside {cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd,
                                      cpuPkg::fnOr, cpuPkg::fnSlt}) begin
          c.regDst   = cpuPkg::regDstRd;
          c.regWrite = 1'b1;
        end
      end
      cpuPkg::opAddi: begin
        c.regSrc1  = 1'b1;
        c.aluSrc1  = cpuPkg::aluSrc1Imm;
        c.regWrite = 1'b1;
      end
      cpuPkg::opLb, cpuPkg::opLh, cpuPkg::opLw: begin
        c.regSrc1  = 1'b1;
        c.aluSrc1  = cpuPkg::aluSrc1Imm;
        c.rdEnable = 1'b1;
        c.memToReg = 1'b1;
        c.regWrite = 1'b1;
        c.rdWidth  = (ins[31:26] == cpuPkg::opLb) ? cpuPkg::widthByte :
                     (ins[31:26] == cpuPkg::opLh) ? cpuPkg::widthHalf : cpuPkg::widthWord;
      end
      cpuPkg::opSb, cpuPkg::opSh, cpuPkg::opSw: begin
        c.aluSrc1  = cpuPkg::aluSrc1Imm;
        c.wrEnable = 1'b1;
        c.wrWidth  = (ins[31:26] == cpuPkg::opSb) ? cpuPkg::widthByte :
                     (ins[31:26] == cpuPkg::opSh) ? cpuPkg::widthHalf : cpuPkg::widthWord;
      end
      cpuPkg::opJ: c.regSrc1 = 1'b1;
      // Link into r31 with PC+4 as operand A
      cpuPkg::opJal: begin
        c.regSrc0  = 1'b1;
        c.regSrc1  = 1'b1;
        c.aluSrc0  = 1'b1;
        c.aluSrc1  = cpuPkg::aluSrc1Zero;
        c.regDst   = cpuPkg::regDstLink;
        c.regWrite = 1'b1;
      end
      // Branches and unknown codes keep the zero bundle
      default: ;
    endcase
    return c;
  endfunction

  always_comb begin
    logic [5:0] op;
    logic       isJr;
    op      = ifInstr[31:26];
    isJr    = (op == cpuPkg::opRType) && (ifInstr[5:0] == cpuPkg::fnJr);
    refCtrl = decodeCtrl(ifInstr);
    srcA    = refCtrl.regSrc0 ? 5'd31 : ifInstr[25:21];
    srcB    = refCtrl.regSrc1 ? 5'd0 : ifInstr[20:16];
    // Same-cycle write is visible to the read
    dataA   = (srcA == 5'd0) ? 32'd0 :
              (wb.regWrite && wb.destReg == srcA) ? wb.data : shadowRegs[srcA];
    dataB   = (srcB == 5'd0) ? 32'd0 :
              (wb.regWrite && wb.destReg == srcB) ? wb.data : shadowRegs[srcB];
    refImm  = {{16{ifInstr[15]}}, ifInstr[15:0]};

    refTaken = ifValid && ((op == cpuPkg::opBeq && dataA == dataB) ||
                           (op == cpuPkg::opBne && dataA != dataB) ||
                           op == cpuPkg::opJ || op == cpuPkg::opJal || isJr);
    if (isJr) begin
      refTarget = dataA;
    end else if (op == cpuPkg::opJ || op == cpuPkg::opJal) begin
      refTarget = {ifPcPlusFour[31:28], ifInstr[25:0], 2'b00};
    end else begin
      refTarget = ifPcPlusFour + {refImm[29:0], 2'b00};
    end

    refEntry.valid      = ifValid;
    refEntry.ctrl       = ifValid ? refCtrl : '0;
    refEntry.regData1   = dataA;
    refEntry.regData2   = dataB;
    refEntry.imm32      = refImm;
    refEntry.destReg    = (refCtrl.regDst == cpuPkg::regDstRd)   ? ifInstr[15:11] :
                          (refCtrl.regDst == cpuPkg::regDstLink) ? 5'd31 : ifInstr[20:16];
    refEntry.pcPlusFour = ifPcPlusFour;
  end

  ////////////////////////////////////////////////////////////
  // Shadow pipeline state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        shadowRegs[i] <= '0;
      end
      ifValid      <= 1'b0;
      ifInstr      <= '0;
      ifPcPlusFour <= '0;
      takenQ       <= 1'b0;
      expIdEx      <= '0;
    end else begin
      if (wb.regWrite && wb.destReg != 5'd0) begin
        shadowRegs[wb.destReg] <= wb.data;
      end
      takenQ <= refTaken;
      // Flush beats stall
      if (refTaken) begin
        ifValid      <= 1'b0;
        ifInstr      <= '0;
        ifPcPlusFour <= '0;
      end else if (!stall) begin
        ifValid      <= 1'b1;
        ifInstr      <= instrData;
        ifPcPlusFour <= instrAddr + 32'd4;
      end
      expIdEx <= stall ? '0 : refEntry;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////
  resetState: assert property (@(posedge clk)
    !rstN |=> (instrAddr == resetPc) && !idEx.valid && !idEx.ctrl.rdEnable &&
              !idEx.ctrl.wrEnable && !idEx.ctrl.regWrite)
    else begin
      failCount++;
      $error("state after reset is wrong");
    end

  sequentialPc: assert property (@(posedge clk) disable iff (!rstN)
    !stall && !refTaken |=> instrAddr == $past(instrAddr) + 32'd4)
    else begin
      failCount++;
      $error("instrAddr did not advance by 4");
    end

  validMatch: assert property (@(posedge clk) disable iff (!rstN)
    idEx.valid == expIdEx.valid)
    else begin
      failCount++;
      $error("idEx valid differs from the reference");
    end

  decodeFields: assert property (@(posedge clk) disable iff (!rstN)
    idEx.valid |-> (idEx.ctrl == expIdEx.ctrl) && (idEx.imm32 == expIdEx.imm32) &&
                   (idEx.destReg == expIdEx.destReg) &&
                   (idEx.pcPlusFour == expIdEx.pcPlusFour))
    else begin
      failCount++;
      $error("idEx control, immediate, dest or PC+4 is wrong");
    end

  regReads: assert property (@(posedge clk) disable iff (!rstN)
    idEx.valid |-> (idEx.regData1 == expIdEx.regData1) &&
                   (idEx.regData2 == expIdEx.regData2))
    else begin
      failCount++;
      $error("idEx register data is wrong");
    end

  // rt forced to r0 must read zero
  zeroReg: assert property (@(posedge clk) disable iff (!rstN)
    idEx.valid && idEx.ctrl.regSrc1 |-> idEx.regData2 == 32'd0)
    else begin
      failCount++;
      $error("register 0 did not read as zero");
    end

  bubbleQuiet: assert property (@(posedge clk) disable iff (!rstN)
    !idEx.valid |-> !idEx.ctrl.rdEnable && !idEx.ctrl.wrEnable && !idEx.ctrl.regWrite)
    else begin
      failCount++;
      $error("bubble carries an enable");
    end

  redirectTarget: assert property (@(posedge clk) disable iff (!rstN)
    refTaken |=> instrAddr == $past(refTarget))
    else begin
      failCount++;
      $error("instrAddr is not the redirect target");
    end

  // Entry after a taken branch or jump comes from the flushed IF/ID
  redirectBubble: assert property (@(posedge clk) disable iff (!rstN)
    takenQ |=> !idEx.valid)
    else begin
      failCount++;
      $error("idEx not a bubble after a redirect");
    end

  stallHold: assert property (@(posedge clk) disable iff (!rstN)
    stall && !refTaken |=> (instrAddr == $past(instrAddr)) && !idEx.valid)
    else begin
      failCount++;
      $error("stall did not hold fetch or bubble idEx");
    end

endmodule

bind cpuFrontEnd cpuFrontEnd_checker #(
  .resetPc (resetPc)
) u_checker (
  .clk       (clk),
  .rstN      (rstN),
  .instrAddr (instrAddr),
  .instrData (instrData),
  .stall     (stall),
  .wb        (wb),
  .idEx      (idEx)
);

`default_nettype wire

//--- dv/tbCpuFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpuFrontEnd;

  localparam logic [31:0] resetPc       = 32'h0000_0100;
  localparam int          memWords      = 256;
  localparam int          timeoutCycles = 40;
  localparam int          burstCount    = 80;

  logic               clk;
  logic               rstN;
  logic               stall;
  logic [31:0]        instrAddr;
  logic [31:0]        instrData;
  cpuPkg::wbPort_t    wb;
  cpuPkg::idExEntry_t idEx;

  // Word-addressed instruction memory that wraps over the address space
  logic [31:0] imem [memWords];

  int          seed;
  int          validCount;
  int          redirectCount;
  int          stallCount;
  logic [31:0] lastAddr;

  ////////////////////////////////////////////////////////////
  // DUT, memory and clock
  ////////////////////////////////////////////////////////////
  cpuFrontEnd #(
    .resetPc (resetPc)
  ) i_cpuFrontEnd (
    .clk       (clk),
    .rstN      (rstN),
    .instrAddr (instrAddr),
    .instrData (instrData),
    .stall     (stall),
    .wb        (wb),
    .idEx      (idEx)
  );

  assign instrData = imem[instrAddr[9:2]];

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on failure");
  endtask

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %h actual %h", testName, expected, actual);
      failRun("value mismatch");
    end
  endtask

  // Program mixing every supported opcode with random fields and immediates
  task automatic fillProgram();
    logic [31:0] r;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    for (int i = 0; i < memWords; i++) begin
      r   = $random(seed);
      rs  = r[4:0];
      rt  = r[9:5];
      rd  = r[14:10];
      imm = r[31:16];
      case (i % 18)
        0:  imem[i] = {cpuPkg::opRType, rs, rt, rd, 5'd0, cpuPkg::fnAdd};
        1:  imem[i] = {cpuPkg::opRType, rs, rt, rd, 5'd0, cpuPkg::fnSub};
        2:  imem[i] = {cpuPkg::opRType, rs, rt, rd, 5'd0, cpuPkg::fnAnd};
        3:  imem[i] = {cpuPkg::opRType, rs, rt, rd, 5'd0, cpuPkg::fnOr};
        4:  imem[i] = {cpuPkg::opRType, rs, rt, rd, 5'd0, cpuPkg::fnSlt};
        5:  imem[i] = {cpuPkg::opAddi, rs, rt, imm};
        6:  imem[i] = {cpuPkg::opLb, rs, rt, imm};
        7:  imem[i] = {cpuPkg::opLh, rs, rt, imm};
        8:  imem[i] = {cpuPkg::opLw, rs, rt, imm};
        9:  imem[i] = {cpuPkg::opSb, rs, rt, imm};
        10: imem[i] = {cpuPkg::opSh, rs, rt, imm};
        11: imem[i] = {cpuPkg::opSw, rs, rt, imm};
        // Same register on both sides for a taken beq now and then
        12: imem[i] = {cpuPkg::opBeq, rs, r[15] ? rs : rt, imm};
        13: imem[i] = {cpuPkg::opBne, rs, rt, imm};
        14: imem[i] = {cpuPkg::opJ, r[25:0]};
        15: imem[i] = {cpuPkg::opJal, r[25:0]};
        16: imem[i] = {cpuPkg::opRType, rs, 15'd0, cpuPkg::fnJr};
        default: imem[i] = {6'h3f, r[25:0]};
      endcase
    end
  endtask

  // One clock cycle with inputs changed on the falling edge
  task automatic stepCycle(input logic stallIn);
    logic [31:0] r;
    @(negedge clk);
    if (i_cpuFrontEnd.u_checker.failCount != 0) begin
      failRun("a checker assertion failed");
    end else begin
      if (rstN) begin
        if (idEx.valid) validCount++;
        if (instrAddr != lastAddr && instrAddr != lastAddr + 32'd4) redirectCount++;
        // Fetch held by the stall of the cycle just ended
        if (stall && instrAddr == lastAddr) stallCount++;
      end
      lastAddr    = instrAddr;
      r           = $random(seed);
      stall       = stallIn;
      wb.regWrite = r[0];
      wb.destReg  = r[5:1];
      wb.data     = $random(seed);
    end
  endtask

  task automatic waitForValid(input string what);
    int n;
    n = 0;
    while (!idEx.valid && n < timeoutCycles) begin
      stepCycle(1'b0);
      n++;
    end
    if (!idEx.valid) begin
      failRun({"timed out waiting for a valid idEx entry ", what});
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    int          runLen;
    int          stallLen;
    seed          = 70308;
    rstN          = 1'b0;
    stall         = 1'b0;
    wb            = '0;
    validCount    = 0;
    redirectCount = 0;
    stallCount    = 0;
    lastAddr      = '0;
    fillProgram();

    repeat (5) stepCycle(1'b0);
    checkValue("reset instrAddr", resetPc, instrAddr);
    checkValue("reset idEx valid", 32'd0, {31'd0, idEx.valid});
    rstN = 1'b1;
    waitForValid("after reset");

    // Free-running stretches separated by stall bursts
    for (int b = 0; b < burstCount; b++) begin
      r        = $random(seed);
      runLen   = 8 + int'(r[3:0]);
      stallLen = 1 + int'(r[5:4]);
      repeat (runLen) stepCycle(1'b0);
      repeat (stallLen) stepCycle(1'b1);
      waitForValid("after stall release");
    end
    stepCycle(1'b0);

    $display("valid entries %0d, redirects %0d, stall cycles %0d",
             validCount, redirectCount, stallCount);
    if (validCount < 200 || redirectCount < 20 || stallCount < 40 ||
        i_cpuFrontEnd.u_checker.failCount != 0) begin
      failRun("stimulus did not reach enough valid entries, redirects or stalls");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the CPU front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tbCpuFrontEnd \
  -Mdir "$buildDir" -o simv
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
  echo "Verilator build failed with status $buildStatus"
  exit 1
fi

# A high error limit lets the testbench itself report checker failures
"./$buildDir/simv" +verilator+error+limit+1000 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "TESTBENCH FAILED" "$logFile"; then
  echo "Simulation reported a failure, see $logFile"
  exit 1
fi
if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi
exit 0

//--- vlog.f
design/cpuPkg.sv
design/instrFetch.sv
design/pipeReg.sv
design/mainControl.sv
design/regFile.sv
design/instrDecode.sv
design/cpuFrontEnd.sv
dv/cpuFrontEnd_checker.sv
dv/tbCpuFrontEnd.sv
